//--- rtl/rx_pkg.sv
// --------------------
// sizes, sample and timestamp types, tagged buffer entry
// --------------------
`default_nettype none

package rx_pkg;

  localparam int SAMPLE_WIDTH = 16;
  localparam int ENTRY_WIDTH  = 32;
  localparam int BUF_DEPTH    = 64;
  localparam int ADDR_WIDTH   = 6;
  // counts 0..BUF_DEPTH inclusive
  localparam int DEPTH_WIDTH  = 7;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // index of a valid sample since reset
  typedef logic [ENTRY_WIDTH-1:0] tstamp_t;

  typedef struct packed {
    logic [ENTRY_WIDTH-SAMPLE_WIDTH-1:0] pad;
    sample_t                             sample;
  } sample_word_t;

  // one data word, read as a sample or as a timestamp
  typedef union packed {
    sample_word_t samp;
    tstamp_t      tstamp;
  } entry_word_u;

  // is_tstamp selects the decoding of word
  typedef struct packed {
    logic        is_tstamp;
    entry_word_u word;
  } entry_t;

endpackage

`default_nettype wire

//--- rtl/buf_rd_if.sv
// --------------------
// buffer read port and capture status
// --------------------
`timescale 1ns/10ps
`default_nettype none

interface buf_rd_if;

  logic                           rd_en;
  logic [rx_pkg::ADDR_WIDTH-1:0]  rd_addr;
  // valid one cycle after rd_en
  rx_pkg::entry_t                 rd_entry;
  logic [rx_pkg::DEPTH_WIDTH-1:0] wr_depth;
  logic                           capturing;

  modport buffer (
    input  rd_en, rd_addr,
    output rd_entry, wr_depth, capturing
  );

  modport readout (
    output rd_en, rd_addr,
    input  rd_entry, wr_depth, capturing
  );

endinterface

`default_nettype wire

//--- rtl/sample_discriminator.sv
// --------------------
// hysteresis gate, sample index counter,
// tagged entry generation
// --------------------
`timescale 1ns/10ps
`default_nettype none

module sample_discriminator (
  input  wire logic           adc_clk,
  input  wire logic           rst_n_i,
  input  wire logic           sample_valid_i,
  input  rx_pkg::sample_t     sample_i,
  input  rx_pkg::sample_t     thresh_high_i,
  input  rx_pkg::sample_t     thresh_low_i,
  input  wire logic           bypass_i,
  output logic                entry_valid_o,
  output rx_pkg::entry_t      entry_o
);

  logic            gate_active;
  rx_pkg::tstamp_t sample_idx;
  logic            burst_open;
  logic            burst_close;
  rx_pkg::entry_t  next_entry;

  // signed compares against the two thresholds
  assign burst_open  = !bypass_i && !gate_active && (sample_i > thresh_high_i);
  assign burst_close = !bypass_i && gate_active && (sample_i < thresh_low_i);

  // burst start carries the index of the opening sample
  always_comb begin
    next_entry = '0;
    if (burst_open) begin
      next_entry.is_tstamp   = 1'b1;
      next_entry.word.tstamp = sample_idx;
    end else begin
      next_entry.is_tstamp          = 1'b0;
      next_entry.word.samp.pad      = '0;
      next_entry.word.samp.sample   = sample_i;
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gate_active   <= 1'b0;
      sample_idx    <= '0;
      entry_valid_o <= 1'b0;
    end else begin
      entry_valid_o <= 1'b0;
      if (sample_valid_i) begin
        sample_idx <= sample_idx + 1'b1;
        if (bypass_i) begin
          gate_active   <= 1'b0;
          entry_valid_o <= 1'b1;
        end else if (burst_open) begin
          gate_active   <= 1'b1;
          entry_valid_o <= 1'b1;
        end else if (burst_close) begin
          // closing sample itself is dropped
          gate_active <= 1'b0;
        end else if (gate_active) begin
          entry_valid_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sample_valid_i) begin
      entry_o <= next_entry;
    end
  end

endmodule

`default_nettype wire

//--- rtl/capture_buffer.sv
// --------------------
// entry memory, arm/stop control, write depth
// --------------------
`timescale 1ns/10ps
`default_nettype none

module capture_buffer (
  input  wire logic     adc_clk,
  input  wire logic     rst_n_i,
  input  wire logic     arm_i,
  input  wire logic     stop_i,
  input  wire logic     entry_valid_i,
  input  rx_pkg::entry_t entry_i,
  buf_rd_if.buffer      rd
);

  rx_pkg::entry_t                 mem [rx_pkg::BUF_DEPTH];
  logic [rx_pkg::DEPTH_WIDTH-1:0] wr_depth;
  logic                           capturing;
  logic                           wr_en;
  logic                           last_slot;

  assign wr_en     = entry_valid_i && capturing;
  assign last_slot = (wr_depth == rx_pkg::DEPTH_WIDTH'(rx_pkg::BUF_DEPTH - 1));

  // arm wins over stop and full in the same cycle
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_depth  <= '0;
      capturing <= 1'b0;
    end else if (arm_i) begin
      wr_depth  <= '0;
      capturing <= 1'b1;
    end else begin
      if (stop_i) begin
        capturing <= 1'b0;
      end
      if (wr_en) begin
        wr_depth <= wr_depth + 1'b1;
        // 64th write fills the memory
        if (last_slot) begin
          capturing <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      mem[wr_depth[rx_pkg::ADDR_WIDTH-1:0]] <= entry_i;
    end
  end

  // synchronous read, one per cycle
  always_ff @(posedge adc_clk) begin
    if (rd.rd_en) begin
      rd.rd_entry <= mem[rd.rd_addr];
    end
  end

  assign rd.wr_depth  = wr_depth;
  assign rd.capturing = capturing;

endmodule

`default_nettype wire

//--- rtl/readout_engine.sv
// --------------------
// sequential reader streaming captured entries
// --------------------
`timescale 1ns/10ps
`default_nettype none

module readout_engine (
  input  wire logic                       adc_clk,
  input  wire logic                       rst_n_i,
  input  wire logic                       readout_start_i,
  buf_rd_if.readout                       rd,
  output logic                            out_valid_o,
  output logic                            out_is_tstamp_o,
  output logic [rx_pkg::ENTRY_WIDTH-1:0]  out_data_o,
  output logic                            readout_done_o
);

  logic                           busy;
  logic                           rd_en_q;
  logic [rx_pkg::ADDR_WIDTH-1:0]  rd_addr_q;
  logic [rx_pkg::DEPTH_WIDTH-1:0] depth_q;
  logic                           fin_q;
  logic                           accept;
  logic                           last_rd;

  // start is ignored while capturing or already reading
  assign accept  = readout_start_i && !rd.capturing && !busy;
  assign last_rd = ({1'b0, rd_addr_q} + 1'b1) == depth_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy           <= 1'b0;
      rd_en_q        <= 1'b0;
      rd_addr_q      <= '0;
      depth_q        <= '0;
      fin_q          <= 1'b0;
      out_valid_o    <= 1'b0;
      readout_done_o <= 1'b0;
    end else begin
      // memory output lags rd_en by one cycle
      out_valid_o    <= rd_en_q;
      readout_done_o <= fin_q;
      fin_q          <= 1'b0;
      if (accept) begin
        busy      <= 1'b1;
        depth_q   <= rd.wr_depth;
        rd_addr_q <= '0;
        rd_en_q   <= (rd.wr_depth != '0);
        // empty buffer goes straight to done
        fin_q     <= (rd.wr_depth == '0);
      end else if (rd_en_q) begin
        rd_addr_q <= rd_addr_q + 1'b1;
        if (last_rd) begin
          rd_en_q <= 1'b0;
          fin_q   <= 1'b1;
        end
      end
      if (fin_q) begin
        busy <= 1'b0;
      end
    end
  end

  assign rd.rd_en   = rd_en_q;
  assign rd.rd_addr = rd_addr_q;

  assign out_is_tstamp_o = rd.rd_entry.is_tstamp;
  assign out_data_o      = rd.rd_entry.word;

endmodule

`default_nettype wire

//--- rtl/receive_top.sv
// --------------------
// receive channel: discriminator, buffer, readout
// --------------------
`timescale 1ns/10ps
`default_nettype none

module receive_top (
  input  wire logic                        adc_clk,
  input  wire logic                        rst_n_i,
  input  wire logic                        sample_valid_i,
  input  rx_pkg::sample_t                  sample_i,
  input  rx_pkg::sample_t                  thresh_high_i,
  input  rx_pkg::sample_t                  thresh_low_i,
  input  wire logic                        bypass_i,
  input  wire logic                        arm_i,
  input  wire logic                        stop_i,
  input  wire logic                        readout_start_i,
  output logic                             capturing_o,
  output logic [rx_pkg::DEPTH_WIDTH-1:0]   wr_depth_o,
  output logic                             out_valid_o,
  output logic                             out_is_tstamp_o,
  output logic [rx_pkg::ENTRY_WIDTH-1:0]   out_data_o,
  output logic                             readout_done_o
);

  logic           entry_valid;
  rx_pkg::entry_t entry;

  buf_rd_if rd_if ();

  sample_discriminator u_disc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .thresh_high_i  (thresh_high_i),
    .thresh_low_i   (thresh_low_i),
    .bypass_i       (bypass_i),
    .entry_valid_o  (entry_valid),
    .entry_o        (entry)
  );

  capture_buffer u_buf (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .arm_i         (arm_i),
    .stop_i        (stop_i),
    .entry_valid_i (entry_valid),
    .entry_i       (entry),
    .rd            (rd_if.buffer)
  );

  readout_engine u_rdout (
    .adc_clk         (adc_clk),
    .rst_n_i         (rst_n_i),
    .readout_start_i (readout_start_i),
    .rd              (rd_if.readout),
    .out_valid_o     (out_valid_o),
    .out_is_tstamp_o (out_is_tstamp_o),
    .out_data_o      (out_data_o),
    .readout_done_o  (readout_done_o)
  );

  // capture status straight from the buffer
  assign capturing_o = rd_if.capturing;
  assign wr_depth_o  = rd_if.wr_depth;

endmodule

`default_nettype wire

//--- verif/receive_checker.sv
// --------------------
// readout checker against expected entries
// --------------------
`timescale 1ns/10ps
`default_nettype none

module receive_checker (
  input  wire logic                           adc_clk,
  input  wire logic                           rst_n_i,
  input  wire logic                           out_valid_i,
  input  wire logic                           out_is_tstamp_i,
  input  wire logic [rx_pkg::ENTRY_WIDTH-1:0] out_data_i,
  input  wire logic                           readout_done_i,
  input  wire logic                           finish_i,
  output int                                  errors_o
);

  logic        exp_flag_q[$];
  logic [31:0] exp_word_q[$];
  int          group_len_q[$];
  int          grp = 0;
  int          got = 0;
  int          pos = 0;
  logic        closed = 1'b0;

  initial begin
    int          fd;
    int          n;
    logic [7:0]  ch;
    logic [31:0] a, b, c, d;
    string       line;
    errors_o = 0;
    fd = $fopen("verif/receive_vectors.txt", "r");
    if (fd == 0) begin
      errors_o++;
      $display("checker cannot open the vectors file");
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, " %c", ch);
        if (n != 1) break;
        if (ch == "#") begin
          n = $fgets(line, fd);
        end else begin
          n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          // a readout record opens a new group of expected entries
          if (ch == "D") group_len_q.push_back(0);
          if (ch == "X" && group_len_q.size() > 0) begin
            for (int k = 0; k < d; k++) begin
              exp_flag_q.push_back(a[0]);
              exp_word_q.push_back(b + k * c);
            end
            group_len_q[group_len_q.size()-1] += d;
          end
        end
      end
      $fclose(fd);
    end
  end

  always @(negedge adc_clk) begin
    if (rst_n_i && !closed) begin
      if (out_valid_i) begin
        if (grp < group_len_q.size() && got < group_len_q[grp]) begin
          if (out_is_tstamp_i !== exp_flag_q[pos]) begin
            errors_o++;
            $display("FAILED t=%0t out_is_tstamp_o expected %0b got %0b",
                     $time, exp_flag_q[pos], out_is_tstamp_i);
          end
          if (out_data_i !== exp_word_q[pos]) begin
            errors_o++;
            $display("FAILED t=%0t out_data_o expected %08h got %08h",
                     $time, exp_word_q[pos], out_data_i);
          end
          pos++;
          got++;
        end else begin
          errors_o++;
          $display("extra readout entry %08h at %0t", out_data_i, $time);
        end
      end
      if (readout_done_i) begin
        if (grp >= group_len_q.size()) begin
          errors_o++;
          $display("unexpected done pulse at %0t", $time);
        end else begin
          if (got < group_len_q[grp]) begin
            errors_o++;
            $display("readout %0d is missing %0d entries", grp, group_len_q[grp] - got);
          end
          pos += group_len_q[grp] - got;
          grp++;
          got = 0;
        end
      end
      if (finish_i) begin
        closed = 1'b1;
        if (grp < group_len_q.size()) begin
          errors_o += group_len_q.size() - grp;
          $display("missing done pulse for %0d readouts", group_len_q.size() - grp);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/receive_asserts.sv
// --------------------
// capture buffer assertions, bound in
// --------------------
`timescale 1ns/10ps
`default_nettype none

module receive_asserts (
  input wire logic       adc_clk,
  input wire logic       rst_n_i,
  input wire logic       arm_i,
  input wire logic       stop_i,
  input wire logic       wr_en,
  input wire logic       capturing,
  input wire logic [6:0] wr_depth
);

  int assert_errors = 0;

  depth_max: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    wr_depth <= 7'(rx_pkg::BUF_DEPTH))
    else begin
      assert_errors++;
      $error("write depth above buffer size");
    end

  // depth only moves on a write
  write_needs_capture: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (!capturing && !arm_i) |=> $stable(wr_depth))
    else begin
      assert_errors++;
      $error("write while not capturing");
    end

  stop_ends_capture: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (stop_i && !arm_i) |=> !capturing)
    else begin
      assert_errors++;
      $error("capturing still high after stop");
    end

  full_ends_capture: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (wr_en && !arm_i && wr_depth == 7'(rx_pkg::BUF_DEPTH - 1)) |=> !capturing)
    else begin
      assert_errors++;
      $error("capturing still high after buffer full");
    end

endmodule

bind capture_buffer receive_asserts u_asserts (
  .adc_clk   (adc_clk),
  .rst_n_i   (rst_n_i),
  .arm_i     (arm_i),
  .stop_i    (stop_i),
  .wr_en     (wr_en),
  .capturing (capturing),
  .wr_depth  (wr_depth)
);

`default_nettype wire

//--- verif/receive_top_tb.sv
// --------------------
// testbench: clock, reset, file-driven stimulus, watchdog
// --------------------
`timescale 1ns/10ps
`default_nettype none

module receive_top_tb;

  localparam string VEC_FILE = "verif/receive_vectors.txt";

  logic                           adc_clk = 1'b0;
  logic                           rst_n_i;
  logic                           sample_valid_i;
  rx_pkg::sample_t                sample_i;
  rx_pkg::sample_t                thresh_high_i;
  rx_pkg::sample_t                thresh_low_i;
  logic                           bypass_i;
  logic                           arm_i;
  logic                           stop_i;
  logic                           readout_start_i;
  logic                           capturing_o;
  logic [rx_pkg::DEPTH_WIDTH-1:0] wr_depth_o;
  logic                           out_valid_o;
  logic                           out_is_tstamp_o;
  logic [rx_pkg::ENTRY_WIDTH-1:0] out_data_o;
  logic                           readout_done_o;

  logic [7:0]  cmd_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] c_q[$];
  int          errors = 0;
  int          chk_errors;
  int          limit = 0;
  logic        finish = 1'b0;

  receive_top dut (.*);

  receive_checker u_checker (
    .adc_clk         (adc_clk),
    .rst_n_i         (rst_n_i),
    .out_valid_i     (out_valid_o),
    .out_is_tstamp_i (out_is_tstamp_o),
    .out_data_i      (out_data_o),
    .readout_done_i  (readout_done_o),
    .finish_i        (finish),
    .errors_o        (chk_errors)
  );

  always #50 adc_clk = ~adc_clk;

  // command records, run length is the sample count plus margin
  task automatic load_commands();
    int          fd;
    int          n;
    logic [7:0]  ch;
    logic [31:0] a, b, c, d;
    string       line;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open vectors file %s", VEC_FILE);
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, " %c", ch);
        if (n != 1) break;
        if (ch == "#") begin
          n = $fgets(line, fd);
        end else begin
          n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          cmd_q.push_back(ch);
          a_q.push_back(a);
          b_q.push_back(b);
          c_q.push_back(c);
          if (ch == "R") limit += c;
        end
      end
      $fclose(fd);
      limit += 200;
    end
  endtask

  task automatic clear_pulses();
    sample_valid_i  <= 1'b0;
    arm_i           <= 1'b0;
    stop_i          <= 1'b0;
    readout_start_i <= 1'b0;
  endtask

  task automatic run_readout(input int depth);
    int waited;
    repeat (3) begin
      @(posedge adc_clk);
      clear_pulses();
    end
    @(negedge adc_clk);
    if (wr_depth_o != depth) begin
      errors++;
      $display("FAILED t=%0t wr_depth_o expected %0d got %0d", $time, depth, wr_depth_o);
    end
    if (capturing_o) begin
      errors++;
      $display("capture still running at %0t when readout should start", $time);
    end
    @(posedge adc_clk);
    readout_start_i <= 1'b1;
    @(posedge adc_clk);
    clear_pulses();
    waited = 0;
    while (!readout_done_o && waited < depth + 8) begin
      @(negedge adc_clk);
      waited++;
    end
  endtask

  task automatic drive_commands();
    int k;
    for (int i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "A": begin
          @(posedge adc_clk);
          clear_pulses();
          thresh_high_i <= 16'(a_q[i]);
          thresh_low_i  <= 16'(b_q[i]);
          bypass_i      <= c_q[i][0];
          arm_i         <= 1'b1;
        end
        "R": begin
          for (k = 0; k < c_q[i]; k++) begin
            @(posedge adc_clk);
            clear_pulses();
            sample_valid_i <= 1'b1;
            sample_i       <= 16'(a_q[i] + k * b_q[i]);
          end
        end
        "P": begin
          @(posedge adc_clk);
          clear_pulses();
          stop_i <= 1'b1;
        end
        "Q": begin
          @(posedge adc_clk);
          clear_pulses();
          readout_start_i <= 1'b1;
        end
        "D": run_readout(a_q[i]);
        default: ;
      endcase
    end
    @(posedge adc_clk);
    clear_pulses();
  endtask

  initial begin
    rst_n_i         = 1'b0;
    sample_valid_i  = 1'b0;
    sample_i        = '0;
    thresh_high_i   = '0;
    thresh_low_i    = '0;
    bypass_i        = 1'b0;
    arm_i           = 1'b0;
    stop_i          = 1'b0;
    readout_start_i = 1'b0;
    load_commands();
    repeat (4) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    drive_commands();
    finish <= 1'b1;
    repeat (3) @(posedge adc_clk);
    $display("errors: testbench %0d, checker %0d, assertions %0d",
             errors, chk_errors, dut.u_buf.u_asserts.assert_errors);
    if (errors + chk_errors + dut.u_buf.u_asserts.assert_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge adc_clk);
    $display("watchdog: run did not end within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/receive_vectors.txt
# cmd a b c d, all hex: A hi lo bypass (arm), R base step count (samples), P stop,
# Q start while capturing, D depth (readout), X flag base step count (expected entries)
A 0100 0080 0 0
R 0050 0 1 0
R 0130 FFFFFFE0 8 0
R 00C0 0 2 0
R 0180 10 3 0
Q 0 0 0 0
P 0 0 0 0
R 01B0 0 4 0
D 9 0 0 0
X 1 1 0 1
X 0 110 FFFFFFE0 5
X 1 B 0 1
X 0 190 10 2
A 0100 0080 1 0
R 0005 3 4 0
P 0 0 0 0
D 4 0 0 0
X 0 5 3 4
A 0100 0080 1 0
R 0100 1 46 0
D 40 0 0 0
X 0 100 1 40
A 0100 0080 0 0
P 0 0 0 0
D 0 0 0 0
A 0100 0080 0 0
R 0300 0 1 0
R 0050 0 1 0
P 0 0 0 0
D 1 0 0 0
X 1 5C 0 1

//--- sim.f
rtl/rx_pkg.sv
rtl/buf_rd_if.sv
rtl/sample_discriminator.sv
rtl/capture_buffer.sv
rtl/readout_engine.sv
rtl/receive_top.sv
verif/receive_checker.sv
verif/receive_asserts.sv
verif/receive_top_tb.sv

//--- Makefile
# Verilator build and run of the receive channel testbench

VERILATOR ?= verilator
TOP       ?= receive_top_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
